/* design/dmemPkg.sv */
`default_nettype none

package dmemPkg;

    localparam int NumCores   = 8;
    localparam int AddrWidth  = 8;
    localparam int DataWidth  = 8;
    localparam int SlotWidth  = 3;               // Index of one core
    localparam int CountWidth = 4;               // Holds 0 to NumCores

    typedef logic [AddrWidth-1:0]  addrT;
    typedef logic [DataWidth-1:0]  dataT;
    typedef logic [SlotWidth-1:0]  slotT;
    typedef logic [CountWidth-1:0] countT;
    typedef logic [NumCores-1:0]   coreMaskT;   // Stall, read, write, available

    // Sequencer walks Issue/Capture pairs for reads, Write cycles for writes
    typedef enum logic [2:0] {
        Idle,
        Issue,
        Capture,
        Write,
        Done
    } seqStateT;

endpackage

`default_nettype wire

/* design/requestDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module requestDecoder
    import dmemPkg::*;
(
    input  wire coreMaskT coreStall,
    input  wire coreMaskT memRead,
    input  wire coreMaskT memWe,
    input  wire addrT     coreAddr [NumCores],
    output countT         activeCount,
    output logic          readReq,
    output logic          writeReq,
    output logic          sameAddr
);

    coreMaskT activeMask;
    logic     anyReq;
    logic     allRead;
    logic     allWrite;

    assign activeMask  = ~coreStall;
    assign activeCount = countT'($countones(activeMask));
    assign anyReq      = |((memRead | memWe) & activeMask);

    // Mixed read/write sets leave both flags low and get ignored
    assign allRead  = ((memRead & activeMask) == activeMask) && ((memWe & activeMask) == '0);
    assign allWrite = ((memWe & activeMask) == activeMask) && ((memRead & activeMask) == '0);

    assign readReq  = (activeCount != '0) && allRead;
    assign writeReq = (activeCount != '0) && allWrite;

    always_comb begin
        sameAddr = 1'b1;
        for (int i = 1; i < NumCores; i++) begin
            if (activeMask[i] && (coreAddr[i] != coreAddr[0])) begin
                sameAddr = 1'b0;
            end
        end
    end

    // Active set must be a block of low bits
    always_comb begin
        if (anyReq) begin
            activeContiguous: assert final ((activeMask & (activeMask + 1'b1)) == '0)
                else $error("active cores not contiguous from core 0: %h", activeMask);
        end
    end

endmodule

`default_nettype wire

/* design/accessSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module accessSequencer
    import dmemPkg::*;
(
    input  wire logic Clk,
    input  wire logic rstN,
    input  wire logic readReq,
    input  wire logic writeReq,
    input  wire logic sameAddr,
    input  wire logic lastSlot,
    output logic      load,
    output logic      step,
    output logic      issueRead,
    output logic      issueWrite,
    output logic      captureOne,
    output logic      captureAll,
    output logic      done
);

    seqStateT state;
    seqStateT nextState;
    logic     bcast;                             // One DRAM read serves all cores

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Broadcast decision is frozen when the request is accepted
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            bcast <= 1'b0;
        end else if (state == Idle && readReq) begin
            bcast <= sameAddr;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (readReq) begin
                    nextState = Issue;
                end else if (writeReq) begin
                    nextState = Write;
                end
            end
            Issue: begin
                nextState = Capture;                 // Data returns one cycle later
            end
            Capture: begin
                if (bcast || lastSlot) begin
                    nextState = Done;
                end else begin
                    nextState = Issue;
                end
            end
            Write: begin
                if (lastSlot) begin
                    nextState = Done;
                end
            end
            Done: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    assign load       = (state == Idle) && (readReq || writeReq);
    assign issueRead  = (state == Issue);
    assign issueWrite = (state == Write);
    assign captureOne = (state == Capture) && !bcast;
    assign captureAll = (state == Capture) && bcast;
    assign done       = (state == Done);

    // Advance to the next core after its capture or its write
    assign step = ((state == Capture) && !bcast && !lastSlot)
               || ((state == Write) && !lastSlot);

    // Cores drop their request on the memAv edge, so Done must not linger
    doneOneCycle: assert property (
        @(posedge Clk) disable iff (!rstN)
        state == Done |=> state == Idle
    ) else $error("Done held longer than one cycle");

    noReadWriteOverlap: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(issueRead && issueWrite)
    ) else $error("issueRead and issueWrite high together");

endmodule

`default_nettype wire

/* design/coreSlotCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSlotCounter
    import dmemPkg::*;
(
    input  wire logic  Clk,
    input  wire logic  rstN,
    input  wire logic  load,
    input  wire logic  step,
    input  wire countT activeCount,
    output slotT       slot,
    output logic       lastSlot
);

    countT slotPlusOne;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            slot <= '0;
        end else if (load) begin
            slot <= '0;                          // Every transaction starts at core 0
        end else if (step) begin
            slot <= slot + 1'b1;
        end
    end

    assign slotPlusOne = countT'(slot) + 1'b1;
    assign lastSlot    = (slotPlusOne == activeCount);

    // Decoder count and sequencer stepping must agree
    stepInRange: assert property (
        @(posedge Clk) disable iff (!rstN)
        step |-> slotPlusOne < activeCount
    ) else $error("slot stepped past active count %0d", activeCount);

endmodule

`default_nettype wire

/* design/dramPortMux.sv */
`timescale 1ns/1ps
`default_nettype none

module dramPortMux
    import dmemPkg::*;
(
    input  wire logic issueRead,
    input  wire logic issueWrite,
    input  wire slotT slot,
    input  wire addrT coreAddr [NumCores],
    input  wire dataT coreData [NumCores],
    output logic      rEn,
    output logic      wEn,
    output addrT      addr,
    output dataT      drOut
);

    assign rEn = issueRead;
    assign wEn = issueWrite;

    // Broadcast reads sit on slot 0, so core 0's address goes out
    assign addr = coreAddr[slot];

    always_comb begin
        if (issueWrite) begin
            drOut = coreData[slot];
        end else begin
            drOut = '0;                          // Quiet bus when not writing
        end
    end

endmodule

`default_nettype wire

/* design/readReturnBank.sv */
`timescale 1ns/1ps
`default_nettype none

module readReturnBank
    import dmemPkg::*;
(
    input  wire logic     Clk,
    input  wire logic     rstN,
    input  wire logic     captureOne,
    input  wire logic     captureAll,
    input  wire logic     done,
    input  wire slotT     slot,
    input  wire coreMaskT coreStall,
    input  wire dataT     memData,
    output dataT          memOut [NumCores],
    output coreMaskT      memAv
);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumCores; i++) begin
                memOut[i] <= '0;
            end
        end else if (captureAll) begin
            for (int i = 0; i < NumCores; i++) begin
                if (!coreStall[i]) begin
                    memOut[i] <= memData;        // Stalled cores keep old data
                end
            end
        end else if (captureOne) begin
            memOut[slot] <= memData;
        end
    end

    // One pulse per transaction for the active cores only
    assign memAv = {NumCores{done}} & ~coreStall;

    oneCaptureKind: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(captureOne && captureAll)
    ) else $error("captureOne and captureAll high together");

endmodule

`default_nettype wire

/* design/dmemController.sv */
`timescale 1ns/1ps
`default_nettype none

module dmemController
    import dmemPkg::*;
(
    input  wire logic     Clk,
    input  wire logic     rstN,
    input  wire coreMaskT coreStall,
    input  wire coreMaskT memRead,
    input  wire coreMaskT memWe,
    input  wire addrT     coreAddr [NumCores],
    input  wire dataT     coreData [NumCores],
    input  wire dataT     memData,               // From DRAM
    output logic          rEn,
    output logic          wEn,
    output addrT          addr,
    output dataT          drOut,
    output dataT          memOut [NumCores],     // To cores
    output coreMaskT      memAv
);

    countT activeCount;
    logic  readReq;
    logic  writeReq;
    logic  sameAddr;
    logic  load;
    logic  step;
    logic  issueRead;
    logic  issueWrite;
    logic  captureOne;
    logic  captureAll;
    logic  done;
    slotT  slot;
    logic  lastSlot;

    requestDecoder u_requestDecoder (
        .coreStall   (coreStall),
        .memRead     (memRead),
        .memWe       (memWe),
        .coreAddr    (coreAddr),
        .activeCount (activeCount),
        .readReq     (readReq),
        .writeReq    (writeReq),
        .sameAddr    (sameAddr)
    );

    accessSequencer u_accessSequencer (
        .Clk        (Clk),
        .rstN       (rstN),
        .readReq    (readReq),
        .writeReq   (writeReq),
        .sameAddr   (sameAddr),
        .lastSlot   (lastSlot),
        .load       (load),
        .step       (step),
        .issueRead  (issueRead),
        .issueWrite (issueWrite),
        .captureOne (captureOne),
        .captureAll (captureAll),
        .done       (done)
    );

    coreSlotCounter u_coreSlotCounter (
        .Clk         (Clk),
        .rstN        (rstN),
        .load        (load),
        .step        (step),
        .activeCount (activeCount),
        .slot        (slot),
        .lastSlot    (lastSlot)
    );

    dramPortMux u_dramPortMux (
        .issueRead  (issueRead),
        .issueWrite (issueWrite),
        .slot       (slot),
        .coreAddr   (coreAddr),
        .coreData   (coreData),
        .rEn        (rEn),
        .wEn        (wEn),
        .addr       (addr),
        .drOut      (drOut)
    );

    readReturnBank u_readReturnBank (
        .Clk        (Clk),
        .rstN       (rstN),
        .captureOne (captureOne),
        .captureAll (captureAll),
        .done       (done),
        .slot       (slot),
        .coreStall  (coreStall),
        .memData    (memData),
        .memOut     (memOut),
        .memAv      (memAv)
    );

endmodule

`default_nettype wire

/* testbench/tbClockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic Clk,
    output logic rstN
);

    localparam int HalfPeriod  = 5;              // 10 ns clock
    localparam int ResetCycles = 10;

    initial begin
        Clk = 1'b0;
        forever #HalfPeriod Clk = ~Clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/dramModel.sv */
`timescale 1ns/1ps
`default_nettype none

module dramModel
    import dmemPkg::*;
(
    input  wire logic Clk,
    input  wire logic rEn,
    input  wire logic wEn,
    input  wire addrT addr,
    input  wire dataT wrData,
    output dataT      rdData
);

    localparam int Depth = 1 << AddrWidth;

    dataT mem [Depth];

    initial begin
        rdData = '0;
        for (int i = 0; i < Depth; i++) begin
            mem[i] = dataT'(i) ^ 8'h5A;          // Every address bit shows up
        end
    end

    always @(posedge Clk) begin
        if (wEn) begin
            mem[addr] <= wrData;
        end
        if (rEn) begin
            rdData <= mem[addr];                 // Valid in the next cycle
        end
    end

endmodule

`default_nettype wire

/* testbench/dmemControllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmemControllerTb
    import dmemPkg::*;
();

    localparam int NumEntries    = 12;
    localparam int ResetCycles   = 10;
    localparam int ResponseLimit = 20;           // Negedges watched per request
    localparam int TimeoutCycles = NumEntries * 40 + ResetCycles;
    localparam int DramDepth     = 1 << AddrWidth;
    localparam int OpRead        = 0;
    localparam int OpWrite       = 1;
    localparam int OpMixed       = 2;

    logic     Clk;
    logic     rstN;
    coreMaskT coreStall;
    coreMaskT memRead;
    coreMaskT memWe;
    addrT     coreAddr [NumCores];
    dataT     coreData [NumCores];
    dataT     memData;
    logic     rEn;
    logic     wEn;
    addrT     addr;
    dataT     drOut;
    dataT     memOut [NumCores];
    coreMaskT memAv;

    int   tabCount [NumEntries];
    int   tabOp [NumEntries];
    addrT tabAddr [NumEntries][NumCores];
    dataT tabData [NumEntries][NumCores];
    dataT mirror [DramDepth];
    dataT expOut [NumCores];
    int   cycleCount = 0;
    int unsigned seedVal = 51;

    tbClockGen u_clk (.Clk(Clk), .rstN(rstN));

    dmemController u_dut (
        .Clk(Clk), .rstN(rstN), .coreStall(coreStall), .memRead(memRead), .memWe(memWe),
        .coreAddr(coreAddr), .coreData(coreData), .memData(memData), .rEn(rEn), .wEn(wEn),
        .addr(addr), .drOut(drOut), .memOut(memOut), .memAv(memAv)
    );

    dramModel u_dram (
        .Clk(Clk), .rEn(rEn), .wEn(wEn), .addr(addr), .wrData(drOut), .rdData(memData)
    );

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stopWithError($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                    name, got, exp));
    endtask

    task automatic checkQuiet();
        expectEqual("rEn", rEn, 0);
        expectEqual("wEn", wEn, 0);
        expectEqual("memAv", memAv, 0);
        for (int k = 0; k < NumCores; k++) begin
            expectEqual($sformatf("memOut[%0d]", k), memOut[k], 0);
        end
    endtask

    // Active cores get base + stride * k, stalled cores random addresses
    task automatic setEntry(input int idx, input int count, input int op,
                            input int base, input int stride);
        for (int k = 0; k < NumCores; k++) begin
            if (k < count) begin
                tabAddr[idx][k] = addrT'(base + stride * k);
            end else begin
                tabAddr[idx][k] = addrT'($urandom);
            end
            tabData[idx][k] = dataT'($urandom);
        end
        tabCount[idx] = count;
        tabOp[idx]    = op;
    endtask

    task automatic applyEntry(input int idx);
        int       cnt;
        int       op;
        int       n;
        int       rdSeen;
        int       wrSeen;
        int       expReads;
        int       expAvAt;
        bit       bcast;
        bit       avSeen;
        coreMaskT active;

        cnt    = tabCount[idx];
        op     = tabOp[idx];
        active = coreMaskT'((1 << cnt) - 1);
        bcast  = 1'b1;
        for (int k = 1; k < cnt; k++) begin
            if (tabAddr[idx][k] != tabAddr[idx][0]) begin
                bcast = 1'b0;
            end
        end
        expReads = bcast ? 1 : cnt;
        // Negedge index 0 lies before the edge that accepts the request
        expAvAt = (op == OpWrite) ? cnt + 1 : (bcast ? 3 : 2 * cnt + 1);

        @(posedge Clk);
        coreStall <= ~active;
        memRead   <= (op == OpRead) ? active : ((op == OpMixed) ? active & 8'h55 : '0);
        memWe     <= (op == OpWrite) ? active : ((op == OpMixed) ? active & 8'hAA : '0);
        for (int k = 0; k < NumCores; k++) begin
            coreAddr[k] <= tabAddr[idx][k];
            coreData[k] <= tabData[idx][k];
        end

        n      = 0;
        rdSeen = 0;
        wrSeen = 0;
        avSeen = 1'b0;
        while (!avSeen && n < ResponseLimit) begin
            @(negedge Clk);
            if (rEn) begin
                assert (op == OpRead && rdSeen < expReads) else
                    stopWithError($sformatf("entry %0d: unexpected DRAM read", idx));
                expectEqual("addr", addr, tabAddr[idx][rdSeen]);
                rdSeen++;
            end
            if (wEn) begin
                assert (op == OpWrite && wrSeen < cnt) else
                    stopWithError($sformatf("entry %0d: unexpected DRAM write", idx));
                expectEqual("addr", addr, tabAddr[idx][wrSeen]);
                expectEqual("drOut", drOut, tabData[idx][wrSeen]);
                wrSeen++;
            end
            if (memAv != '0) begin
                avSeen = 1'b1;
                assert (op != OpMixed) else
                    stopWithError($sformatf("entry %0d: mixed request was served", idx));
                expectEqual("memAv", memAv, active);
                expectEqual("memAv cycle", n, expAvAt);
            end
            n++;
        end
        assert (avSeen || op == OpMixed) else
            stopWithError($sformatf("entry %0d: memAv never arrived", idx));
        expectEqual("rEn cycles", rdSeen, (op == OpRead) ? expReads : 0);
        expectEqual("wEn cycles", wrSeen, (op == OpWrite) ? cnt : 0);

        // Stalled cores and unserved requests leave memOut alone
        for (int k = 0; k < NumCores; k++) begin
            if (op == OpRead && active[k]) begin
                expOut[k] = mirror[tabAddr[idx][k]];
            end
            expectEqual($sformatf("memOut[%0d]", k), memOut[k], expOut[k]);
        end
        if (op == OpWrite) begin
            for (int k = 0; k < cnt; k++) begin
                mirror[tabAddr[idx][k]] = tabData[idx][k];
            end
        end

        @(posedge Clk);
        memRead <= '0;                           // Drop on the memAv edge
        memWe   <= '0;
        @(negedge Clk);
        expectEqual("memAv after pulse", memAv, 0);
        expectEqual("rEn after pulse", rEn, 0);
        expectEqual("wEn after pulse", wEn, 0);
        if (op == OpWrite) begin
            for (int a = 0; a < DramDepth; a++) begin
                expectEqual($sformatf("dram[0x%0h]", a), u_dram.mem[a], mirror[a]);
            end
        end
    endtask

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            stopWithError("timeout: the run did not finish in the allowed cycles");
        end
    end

    initial begin
        coreStall = '1;
        memRead   = '0;
        memWe     = '0;
        for (int k = 0; k < NumCores; k++) begin
            coreAddr[k] = '0;
            coreData[k] = '0;
            expOut[k]   = '0;
        end
        for (int a = 0; a < DramDepth; a++) begin
            mirror[a] = dataT'(a) ^ 8'h5A;
        end
        void'($urandom(seedVal));

        setEntry(0, 8, OpWrite, 8'h10, 1);
        setEntry(1, 8, OpRead, 8'h13, 0);        // Broadcast
        setEntry(2, 8, OpRead, 8'h17, -1);
        setEntry(3, 3, OpWrite, 8'h40, 5);
        setEntry(4, 3, OpRead, 8'h4A, -5);
        setEntry(5, 1, OpRead, 8'h45, 0);
        setEntry(6, 5, OpRead, 8'h12, 0);        // Broadcast with stalled cores
        setEntry(7, 4, OpMixed, 8'h30, 1);
        setEntry(8, 1, OpWrite, 8'h80, 0);
        setEntry(9, 2, OpRead, 8'h80, 3);
        setEntry(10, 6, OpWrite, 8'hF0, 2);
        setEntry(11, 8, OpRead, 8'hFA, -2);

        repeat (ResetCycles) begin
            @(negedge Clk);
            checkQuiet();
        end
        wait (rstN === 1'b1);
        @(negedge Clk);
        checkQuiet();

        for (int i = 0; i < NumEntries; i++) begin
            applyEntry(i);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* dmemController.f */
design/dmemPkg.sv
design/requestDecoder.sv
design/accessSequencer.sv
design/coreSlotCounter.sv
design/dramPortMux.sv
design/readReturnBank.sv
design/dmemController.sv
testbench/tbClockGen.sv
testbench/dramModel.sv
testbench/dmemControllerTb.sv
